//--- mshr_consts.svh
`ifndef MSHR_CONSTS_SVH
`define MSHR_CONSTS_SVH

// MSHR geometry
`define MSHR_SETS       4
`define MSHR_WAYS       2
`define MSHR_SET_WIDTH  2
`define MSHR_WAY_WIDTH  1

// Line number and its two splits
`define NLINE_WIDTH     16
`define CACHE_SET_WIDTH 6
`define MSHR_TAG_WIDTH  (`NLINE_WIDTH - `MSHR_SET_WIDTH)
`define CACHE_TAG_WIDTH (`NLINE_WIDTH - `CACHE_SET_WIDTH)

// Request fields
`define REQ_ID_WIDTH    4
`define WORD_WIDTH      3

// Stored entry is tag, request id, word and need_rsp
`define MSHR_ENTRY_WIDTH (`MSHR_TAG_WIDTH + `REQ_ID_WIDTH + `WORD_WIDTH + 1)

`endif

//--- mshr_pkg.sv
`include "mshr_consts.svh"

package mshr_pkg;

    // One line number, seen either by the MSHR or by the data cache
    typedef union packed {
        struct packed {
            logic [`MSHR_TAG_WIDTH-1:0] mtag;
            logic [`MSHR_SET_WIDTH-1:0] mset;
        } mshr;
        struct packed {
            logic [`CACHE_TAG_WIDTH-1:0] ctag;
            logic [`CACHE_SET_WIDTH-1:0] cset;
        } cache;
    } nline_u;

    // Outcome of a miss request decode
    typedef enum logic [1:0] {
        MISS_ALLOC   = 2'd0,
        MISS_PENDING = 2'd1,
        MISS_FULL    = 2'd2
    } miss_status_e;

endpackage

//--- mshr_sram.sv
`timescale 1ns/100ps
`include "mshr_consts.svh"

module mshr_sram (
    input  logic                                    clk_i,
    input  logic                                    cs_i,
    input  logic                                    we_i,
    input  logic [`MSHR_SET_WIDTH-1:0]              addr_i,
    input  logic [`MSHR_WAYS-1:0]                   wmask_i,
    input  logic [`MSHR_ENTRY_WIDTH-1:0]            wdata_i,
    output logic [`MSHR_WAYS*`MSHR_ENTRY_WIDTH-1:0] rdata_o
);

    logic [`MSHR_ENTRY_WIDTH-1:0] mem [`MSHR_SETS][`MSHR_WAYS];

    // Write touches only the masked ways
    always_ff @(posedge clk_i) begin
        if (cs_i && we_i) begin
            for (int w = 0; w < `MSHR_WAYS; w++) begin
                if (wmask_i[w]) begin
                    mem[addr_i][w] <= wdata_i;
                end
            end
        end
    end

    // Whole set comes back one cycle after the read
    always_ff @(posedge clk_i) begin
        if (cs_i && !we_i) begin
            for (int w = 0; w < `MSHR_WAYS; w++) begin
                rdata_o[w*`MSHR_ENTRY_WIDTH +: `MSHR_ENTRY_WIDTH] <= mem[addr_i][w];
            end
        end
    end

endmodule

//--- mshr.sv
`timescale 1ns/100ps
`include "mshr_consts.svh"

module mshr (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         check_i,
    input  mshr_pkg::nline_u             check_nline_i,
    input  logic                         alloc_i,
    input  mshr_pkg::nline_u             alloc_nline_i,
    input  logic [`REQ_ID_WIDTH-1:0]     alloc_req_id_i,
    input  logic [`WORD_WIDTH-1:0]       alloc_word_i,
    input  logic                         alloc_need_rsp_i,
    input  logic                         ack_i,
    input  logic [`MSHR_SET_WIDTH-1:0]   ack_set_i,
    input  logic [`MSHR_WAY_WIDTH-1:0]   ack_way_i,
    output logic                         hit_o,
    output logic                         alloc_full_o,
    output logic [`MSHR_SET_WIDTH-1:0]   alloc_set_o,
    output logic [`MSHR_WAY_WIDTH-1:0]   alloc_way_o,
    output mshr_pkg::nline_u             ack_nline_o,
    output logic [`REQ_ID_WIDTH-1:0]     ack_req_id_o,
    output logic [`WORD_WIDTH-1:0]       ack_word_o,
    output logic                         ack_need_rsp_o,
    output logic                         empty_o,
    output logic                         full_o
);

    // Tag sits at the top of each stored entry
    localparam int TAG_LSB = `MSHR_ENTRY_WIDTH - `MSHR_TAG_WIDTH;

    logic [`MSHR_SETS-1:0][`MSHR_WAYS-1:0]   valid_q;
    logic [`MSHR_SET_WIDTH-1:0]              check_set_q;
    logic [`MSHR_TAG_WIDTH-1:0]              check_tag_q;
    logic [`MSHR_SET_WIDTH-1:0]              ack_set_q;
    logic [`MSHR_WAY_WIDTH-1:0]              ack_way_q;
    logic [`MSHR_SET_WIDTH-1:0]              alloc_set;

    logic                                    sram_cs;
    logic                                    sram_we;
    logic [`MSHR_SET_WIDTH-1:0]              sram_addr;
    logic [`MSHR_WAYS-1:0]                   sram_wmask;
    logic [`MSHR_ENTRY_WIDTH-1:0]            sram_wdata;
    logic [`MSHR_WAYS*`MSHR_ENTRY_WIDTH-1:0] sram_rdata;
    logic [`MSHR_ENTRY_WIDTH-1:0]            ack_entry;
    logic [`MSHR_TAG_WIDTH-1:0]              ack_tag;

    assign alloc_set   = alloc_nline_i.mshr.mset;
    assign alloc_set_o = alloc_set;

    // Lowest free way wins, so scan downwards
    always_comb begin
        alloc_way_o = '0;
        for (int w = `MSHR_WAYS - 1; w >= 0; w--) begin
            if (!valid_q[alloc_set][w]) begin
                alloc_way_o = `MSHR_WAY_WIDTH'(w);
            end
        end
    end

    assign alloc_full_o = &valid_q[check_set_q];

    // Hit on any valid way whose stored tag matches
    always_comb begin
        hit_o = 1'b0;
        for (int w = 0; w < `MSHR_WAYS; w++) begin
            if (valid_q[check_set_q][w] &&
                sram_rdata[w*`MSHR_ENTRY_WIDTH + TAG_LSB +: `MSHR_TAG_WIDTH] == check_tag_q) begin
                hit_o = 1'b1;
            end
        end
    end

    // Storage port, ack first, then alloc, then check
    assign sram_cs    = ack_i | alloc_i | check_i;
    assign sram_we    = alloc_i & ~ack_i;
    assign sram_addr  = ack_i   ? ack_set_i :
                        alloc_i ? alloc_set : check_nline_i.mshr.mset;
    assign sram_wmask = `MSHR_WAYS'(1) << alloc_way_o;
    assign sram_wdata = {alloc_nline_i.mshr.mtag, alloc_req_id_i, alloc_word_i, alloc_need_rsp_i};

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            valid_q     <= '0;
            check_set_q <= '0;
            check_tag_q <= '0;
            ack_set_q   <= '0;
            ack_way_q   <= '0;
        end else begin
            if (alloc_i) begin
                valid_q[alloc_set][alloc_way_o] <= 1'b1;
            end
            if (ack_i) begin
                valid_q[ack_set_i][ack_way_i] <= 1'b0;
                ack_set_q <= ack_set_i;
                ack_way_q <= ack_way_i;
            end
            if (check_i) begin
                check_set_q <= check_nline_i.mshr.mset;
                check_tag_q <= check_nline_i.mshr.mtag;
            end
        end
    end

    mshr_sram u_sram (
        .clk_i   (clk_i),
        .cs_i    (sram_cs),
        .we_i    (sram_we),
        .addr_i  (sram_addr),
        .wmask_i (sram_wmask),
        .wdata_i (sram_wdata),
        .rdata_o (sram_rdata)
    );

    // Released entry, line rebuilt from stored tag and acked set
    assign ack_entry = sram_rdata[ack_way_q*`MSHR_ENTRY_WIDTH +: `MSHR_ENTRY_WIDTH];
    assign {ack_tag, ack_req_id_o, ack_word_o, ack_need_rsp_o} = ack_entry;

    always_comb begin
        ack_nline_o.mshr.mtag = ack_tag;
        ack_nline_o.mshr.mset = ack_set_q;
    end

    assign empty_o = ~|valid_q;
    assign full_o  = &valid_q;

endmodule

//--- miss_req_decode.sv
`timescale 1ns/100ps
`include "mshr_consts.svh"

module miss_req_decode (
    input  logic                         clk_i,
    input  logic                         rst_ni,
    input  logic                         miss_req_i,
    input  mshr_pkg::nline_u             miss_nline_i,
    input  logic [`REQ_ID_WIDTH-1:0]     miss_req_id_i,
    input  logic [`WORD_WIDTH-1:0]       miss_word_i,
    input  logic                         miss_need_rsp_i,
    input  logic                         hit_i,
    input  logic                         alloc_full_i,
    input  logic [`MSHR_SET_WIDTH-1:0]   alloc_set_i,
    input  logic [`MSHR_WAY_WIDTH-1:0]   alloc_way_i,
    output logic                         check_o,
    output mshr_pkg::nline_u             check_nline_o,
    output logic                         alloc_o,
    output mshr_pkg::nline_u             alloc_nline_o,
    output logic [`REQ_ID_WIDTH-1:0]     alloc_req_id_o,
    output logic [`WORD_WIDTH-1:0]       alloc_word_o,
    output logic                         alloc_need_rsp_o,
    output logic                         dec_valid_o,
    output mshr_pkg::miss_status_e       dec_status_o,
    output logic                         mem_req_o,
    output mshr_pkg::nline_u             mem_nline_o,
    output logic [`MSHR_SET_WIDTH-1:0]   mem_set_o,
    output logic [`MSHR_WAY_WIDTH-1:0]   mem_way_o
);

    logic                        req_valid_q;
    mshr_pkg::nline_u            nline_q;
    logic [`REQ_ID_WIDTH-1:0]    req_id_q;
    logic [`WORD_WIDTH-1:0]      word_q;
    logic                        need_rsp_q;

    // Lookup goes out in the same cycle as the strobe
    assign check_o       = miss_req_i;
    assign check_nline_o = miss_nline_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            req_valid_q <= 1'b0;
        end else begin
            req_valid_q <= miss_req_i;
        end
    end

    // Held request fields
    always_ff @(posedge clk_i) begin
        if (miss_req_i) begin
            nline_q    <= miss_nline_i;
            req_id_q   <= miss_req_id_i;
            word_q     <= miss_word_i;
            need_rsp_q <= miss_need_rsp_i;
        end
    end

    // A pending line wins over a full set
    always_comb begin
        if (hit_i) begin
            dec_status_o = mshr_pkg::MISS_PENDING;
        end else if (alloc_full_i) begin
            dec_status_o = mshr_pkg::MISS_FULL;
        end else begin
            dec_status_o = mshr_pkg::MISS_ALLOC;
        end
    end

    assign dec_valid_o      = req_valid_q;
    assign alloc_o          = req_valid_q & ~hit_i & ~alloc_full_i;
    assign alloc_nline_o    = nline_q;
    assign alloc_req_id_o   = req_id_q;
    assign alloc_word_o     = word_q;
    assign alloc_need_rsp_o = need_rsp_q;

    // Memory read tagged with the slot the MSHR hands over
    assign mem_req_o   = alloc_o;
    assign mem_nline_o = nline_q;
    assign mem_set_o   = alloc_set_i;
    assign mem_way_o   = alloc_way_i;

endmodule

//--- miss_refill.sv
`timescale 1ns/100ps
`include "mshr_consts.svh"

module miss_refill (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          refill_i,
    input  logic [`MSHR_SET_WIDTH-1:0]    refill_set_i,
    input  logic [`MSHR_WAY_WIDTH-1:0]    refill_way_i,
    input  mshr_pkg::nline_u              ack_nline_i,
    input  logic [`REQ_ID_WIDTH-1:0]      ack_req_id_i,
    input  logic [`WORD_WIDTH-1:0]        ack_word_i,
    input  logic                          ack_need_rsp_i,
    output logic                          ack_o,
    output logic [`MSHR_SET_WIDTH-1:0]    ack_set_o,
    output logic [`MSHR_WAY_WIDTH-1:0]    ack_way_o,
    output logic                          rsp_valid_o,
    output logic [`REQ_ID_WIDTH-1:0]      rsp_req_id_o,
    output logic [`WORD_WIDTH-1:0]        rsp_word_o,
    output logic [`CACHE_SET_WIDTH-1:0]   rsp_cache_set_o,
    output logic [`CACHE_TAG_WIDTH-1:0]   rsp_cache_tag_o
);

    logic rsp_pend_q;

    // Refill frees its slot right away
    assign ack_o     = refill_i;
    assign ack_set_o = refill_set_i;
    assign ack_way_o = refill_way_i;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rsp_pend_q <= 1'b0;
        end else begin
            rsp_pend_q <= refill_i;
        end
    end

    // Prefetch-like entries only free the slot
    assign rsp_valid_o  = rsp_pend_q & ack_need_rsp_i;
    assign rsp_req_id_o = ack_req_id_i;
    assign rsp_word_o   = ack_word_i;

    // Line goes back out split the cache way
    assign rsp_cache_set_o = ack_nline_i.cache.cset;
    assign rsp_cache_tag_o = ack_nline_i.cache.ctag;

endmodule

//--- miss_handler_top.sv
`timescale 1ns/100ps
`include "mshr_consts.svh"

module miss_handler_top (
    input  logic                          clk_i,
    input  logic                          rst_ni,
    input  logic                          miss_req_i,
    input  mshr_pkg::nline_u              miss_nline_i,
    input  logic [`REQ_ID_WIDTH-1:0]      miss_req_id_i,
    input  logic [`WORD_WIDTH-1:0]        miss_word_i,
    input  logic                          miss_need_rsp_i,
    output logic                          dec_valid_o,
    output mshr_pkg::miss_status_e        dec_status_o,
    output logic                          mem_req_o,
    output mshr_pkg::nline_u              mem_nline_o,
    output logic [`MSHR_SET_WIDTH-1:0]    mem_set_o,
    output logic [`MSHR_WAY_WIDTH-1:0]    mem_way_o,
    input  logic                          refill_i,
    input  logic [`MSHR_SET_WIDTH-1:0]    refill_set_i,
    input  logic [`MSHR_WAY_WIDTH-1:0]    refill_way_i,
    output logic                          rsp_valid_o,
    output logic [`REQ_ID_WIDTH-1:0]      rsp_req_id_o,
    output logic [`WORD_WIDTH-1:0]        rsp_word_o,
    output logic [`CACHE_SET_WIDTH-1:0]   rsp_cache_set_o,
    output logic [`CACHE_TAG_WIDTH-1:0]   rsp_cache_tag_o,
    output logic                          empty_o,
    output logic                          full_o
);

    logic                        check;
    mshr_pkg::nline_u            check_nline;
    logic                        hit;
    logic                        alloc_full;
    logic [`MSHR_SET_WIDTH-1:0]  alloc_set;
    logic [`MSHR_WAY_WIDTH-1:0]  alloc_way;
    logic                        alloc;
    mshr_pkg::nline_u            alloc_nline;
    logic [`REQ_ID_WIDTH-1:0]    alloc_req_id;
    logic [`WORD_WIDTH-1:0]      alloc_word;
    logic                        alloc_need_rsp;
    logic                        ack;
    logic [`MSHR_SET_WIDTH-1:0]  ack_set;
    logic [`MSHR_WAY_WIDTH-1:0]  ack_way;
    mshr_pkg::nline_u            ack_nline;
    logic [`REQ_ID_WIDTH-1:0]    ack_req_id;
    logic [`WORD_WIDTH-1:0]      ack_word;
    logic                        ack_need_rsp;

    miss_req_decode u_decode (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .miss_req_i       (miss_req_i),
        .miss_nline_i     (miss_nline_i),
        .miss_req_id_i    (miss_req_id_i),
        .miss_word_i      (miss_word_i),
        .miss_need_rsp_i  (miss_need_rsp_i),
        .hit_i            (hit),
        .alloc_full_i     (alloc_full),
        .alloc_set_i      (alloc_set),
        .alloc_way_i      (alloc_way),
        .check_o          (check),
        .check_nline_o    (check_nline),
        .alloc_o          (alloc),
        .alloc_nline_o    (alloc_nline),
        .alloc_req_id_o   (alloc_req_id),
        .alloc_word_o     (alloc_word),
        .alloc_need_rsp_o (alloc_need_rsp),
        .dec_valid_o      (dec_valid_o),
        .dec_status_o     (dec_status_o),
        .mem_req_o        (mem_req_o),
        .mem_nline_o      (mem_nline_o),
        .mem_set_o        (mem_set_o),
        .mem_way_o        (mem_way_o)
    );

    mshr u_mshr (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .check_i          (check),
        .check_nline_i    (check_nline),
        .alloc_i          (alloc),
        .alloc_nline_i    (alloc_nline),
        .alloc_req_id_i   (alloc_req_id),
        .alloc_word_i     (alloc_word),
        .alloc_need_rsp_i (alloc_need_rsp),
        .ack_i            (ack),
        .ack_set_i        (ack_set),
        .ack_way_i        (ack_way),
        .hit_o            (hit),
        .alloc_full_o     (alloc_full),
        .alloc_set_o      (alloc_set),
        .alloc_way_o      (alloc_way),
        .ack_nline_o      (ack_nline),
        .ack_req_id_o     (ack_req_id),
        .ack_word_o       (ack_word),
        .ack_need_rsp_o   (ack_need_rsp),
        .empty_o          (empty_o),
        .full_o           (full_o)
    );

    miss_refill u_refill (
        .clk_i            (clk_i),
        .rst_ni           (rst_ni),
        .refill_i         (refill_i),
        .refill_set_i     (refill_set_i),
        .refill_way_i     (refill_way_i),
        .ack_nline_i      (ack_nline),
        .ack_req_id_i     (ack_req_id),
        .ack_word_i       (ack_word),
        .ack_need_rsp_i   (ack_need_rsp),
        .ack_o            (ack),
        .ack_set_o        (ack_set),
        .ack_way_o        (ack_way),
        .rsp_valid_o      (rsp_valid_o),
        .rsp_req_id_o     (rsp_req_id_o),
        .rsp_word_o       (rsp_word_o),
        .rsp_cache_set_o  (rsp_cache_set_o),
        .rsp_cache_tag_o  (rsp_cache_tag_o)
    );

endmodule

//--- miss_handler_asserts.sv
`timescale 1ns/100ps

module miss_handler_asserts (
    input logic clk_i,
    input logic rst_ni,
    input logic miss_req_i,
    input logic refill_i,
    input logic dec_valid_o
);

    // Requester leaves a gap cycle after each strobe
    a_req_gap: assert property (@(posedge clk_i) disable iff (!rst_ni)
        miss_req_i |=> !miss_req_i)
        else $error("miss_req_i in the cycle right after a miss_req_i");

    // Refill stays clear of a request and the cycle after it
    a_refill_same: assert property (@(posedge clk_i) disable iff (!rst_ni)
        miss_req_i |-> !refill_i)
        else $error("refill_i together with miss_req_i");

    a_refill_next: assert property (@(posedge clk_i) disable iff (!rst_ni)
        miss_req_i |=> !refill_i)
        else $error("refill_i in the cycle after miss_req_i");

    // Decode answers exactly one cycle later
    a_dec_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        miss_req_i |=> dec_valid_o)
        else $error("no dec_valid_o one cycle after miss_req_i");

    a_dec_only_after_req: assert property (@(posedge clk_i) disable iff (!rst_ni)
        dec_valid_o |-> $past(miss_req_i))
        else $error("dec_valid_o without a miss_req_i one cycle earlier");

endmodule

bind miss_handler_top miss_handler_asserts u_asserts (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .miss_req_i  (miss_req_i),
    .refill_i    (refill_i),
    .dec_valid_o (dec_valid_o)
);

//--- tb_miss_handler.sv
`timescale 1ns/100ps
`include "mshr_consts.svh"

module tb_miss_handler;

    localparam int CLK_PERIOD  = 40;
    localparam int RST_CYCLES  = 5;
    localparam int NUM_ROWS    = 25;
    // Two cycles per row, plus reset and some slack
    localparam int WATCHDOG_NS = (NUM_ROWS * 2 + RST_CYCLES + 20) * CLK_PERIOD;

    logic                           clk_i;
    logic                           rst_ni;
    logic                           miss_req;
    mshr_pkg::nline_u               miss_nline;
    logic [`REQ_ID_WIDTH-1:0]       miss_req_id;
    logic [`WORD_WIDTH-1:0]         miss_word;
    logic                           miss_need_rsp;
    logic                           refill;
    logic [`MSHR_SET_WIDTH-1:0]     refill_set;
    logic [`MSHR_WAY_WIDTH-1:0]     refill_way;
    logic                           dec_valid;
    mshr_pkg::miss_status_e         dec_status;
    logic                           mem_req;
    mshr_pkg::nline_u               mem_nline;
    logic [`MSHR_SET_WIDTH-1:0]     mem_set;
    logic [`MSHR_WAY_WIDTH-1:0]     mem_way;
    logic                           rsp_valid;
    logic [`REQ_ID_WIDTH-1:0]       rsp_req_id;
    logic [`WORD_WIDTH-1:0]         rsp_word;
    logic [`CACHE_SET_WIDTH-1:0]    rsp_cache_set;
    logic [`CACHE_TAG_WIDTH-1:0]    rsp_cache_tag;
    logic                           empty;
    logic                           full;

    // Stimulus table, one entry per row
    logic                           row_is_refill [NUM_ROWS];
    logic [`NLINE_WIDTH-1:0]        row_nline     [NUM_ROWS];
    logic [`REQ_ID_WIDTH-1:0]       row_req_id    [NUM_ROWS];
    logic [`WORD_WIDTH-1:0]         row_word      [NUM_ROWS];
    logic                           row_need_rsp  [NUM_ROWS];
    logic [`MSHR_SET_WIDTH-1:0]     row_set       [NUM_ROWS];
    logic [`MSHR_WAY_WIDTH-1:0]     row_way       [NUM_ROWS];
    mshr_pkg::miss_status_e         row_status    [NUM_ROWS];
    logic                           row_rsp       [NUM_ROWS];
    int                             n_rows;

    // Reference model of the MSHR slots
    logic                           ref_valid    [`MSHR_SETS][`MSHR_WAYS];
    logic [`NLINE_WIDTH-1:0]        ref_nline    [`MSHR_SETS][`MSHR_WAYS];
    logic [`REQ_ID_WIDTH-1:0]       ref_req_id   [`MSHR_SETS][`MSHR_WAYS];
    logic [`WORD_WIDTH-1:0]         ref_word     [`MSHR_SETS][`MSHR_WAYS];
    logic                           ref_need_rsp [`MSHR_SETS][`MSHR_WAYS];

    int                             seed;
    int                             errors;
    int                             row_errors;
    int                             failed_rows;

    miss_handler_top u_dut (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .miss_req_i      (miss_req),
        .miss_nline_i    (miss_nline),
        .miss_req_id_i   (miss_req_id),
        .miss_word_i     (miss_word),
        .miss_need_rsp_i (miss_need_rsp),
        .dec_valid_o     (dec_valid),
        .dec_status_o    (dec_status),
        .mem_req_o       (mem_req),
        .mem_nline_o     (mem_nline),
        .mem_set_o       (mem_set),
        .mem_way_o       (mem_way),
        .refill_i        (refill),
        .refill_set_i    (refill_set),
        .refill_way_i    (refill_way),
        .rsp_valid_o     (rsp_valid),
        .rsp_req_id_o    (rsp_req_id),
        .rsp_word_o      (rsp_word),
        .rsp_cache_set_o (rsp_cache_set),
        .rsp_cache_tag_o (rsp_cache_tag),
        .empty_o         (empty),
        .full_o          (full)
    );

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic add_request(input logic [`NLINE_WIDTH-1:0] nline, input logic need_rsp,
                               input mshr_pkg::miss_status_e status);
        row_is_refill[n_rows] = 1'b0;
        row_nline[n_rows]     = nline;
        row_req_id[n_rows]    = `REQ_ID_WIDTH'($random(seed));
        row_word[n_rows]      = `WORD_WIDTH'($random(seed));
        row_need_rsp[n_rows]  = need_rsp;
        row_set[n_rows]       = '0;
        row_way[n_rows]       = '0;
        row_status[n_rows]    = status;
        row_rsp[n_rows]       = 1'b0;
        n_rows++;
    endtask

    task automatic add_refill(input int set, input int way, input logic rsp);
        row_is_refill[n_rows] = 1'b1;
        row_nline[n_rows]     = '0;
        row_req_id[n_rows]    = '0;
        row_word[n_rows]      = '0;
        row_need_rsp[n_rows]  = 1'b0;
        row_set[n_rows]       = `MSHR_SET_WIDTH'(set);
        row_way[n_rows]       = `MSHR_WAY_WIDTH'(way);
        row_status[n_rows]    = mshr_pkg::MISS_ALLOC;
        row_rsp[n_rows]       = rsp;
        n_rows++;
    endtask

    task automatic load_table();
        n_rows = 0;
        // Set 0 fills up, rejects, then frees and reallocates way 0
        add_request(16'h1234, 1'b1, mshr_pkg::MISS_ALLOC);
        add_request(16'h1234, 1'b1, mshr_pkg::MISS_PENDING);
        add_request(16'h5678, 1'b0, mshr_pkg::MISS_ALLOC);
        add_request(16'h9abc, 1'b1, mshr_pkg::MISS_FULL);
        add_request(16'h1234, 1'b0, mshr_pkg::MISS_PENDING);
        add_refill(0, 0, 1'b1);
        add_request(16'h1234, 1'b1, mshr_pkg::MISS_ALLOC);
        add_refill(0, 1, 1'b0);
        // Fill all eight slots
        add_request(16'h9abc, 1'b1, mshr_pkg::MISS_ALLOC);
        add_request(16'h1111, 1'b0, mshr_pkg::MISS_ALLOC);
        add_request(16'hc0d5, 1'b1, mshr_pkg::MISS_ALLOC);
        add_request(16'h2222, 1'b1, mshr_pkg::MISS_ALLOC);
        add_request(16'hfaca, 1'b0, mshr_pkg::MISS_ALLOC);
        add_request(16'hbeef, 1'b1, mshr_pkg::MISS_ALLOC);
        add_request(16'h7773, 1'b1, mshr_pkg::MISS_ALLOC);
        add_request(16'h3330, 1'b1, mshr_pkg::MISS_FULL);
        add_request(16'hbeef, 1'b0, mshr_pkg::MISS_PENDING);
        // Drain everything back to empty
        add_refill(0, 0, 1'b1);
        add_refill(0, 1, 1'b1);
        add_refill(1, 0, 1'b0);
        add_refill(1, 1, 1'b1);
        add_refill(2, 0, 1'b1);
        add_refill(2, 1, 1'b0);
        add_refill(3, 0, 1'b1);
        add_refill(3, 1, 1'b1);
    endtask

    // Pending over full over allocate, lowest free way
    task automatic predict_request(input logic [`NLINE_WIDTH-1:0] nline,
                                   output mshr_pkg::miss_status_e status,
                                   output logic [`MSHR_WAY_WIDTH-1:0] way);
        int  set;
        logic hit;
        logic found;
        set   = int'(nline[`MSHR_SET_WIDTH-1:0]);
        hit   = 1'b0;
        found = 1'b0;
        way   = '0;
        for (int w = 0; w < `MSHR_WAYS; w++) begin
            if (ref_valid[set][w] && ref_nline[set][w] == nline) begin
                hit = 1'b1;
            end
            if (!ref_valid[set][w] && !found) begin
                found = 1'b1;
                way   = `MSHR_WAY_WIDTH'(w);
            end
        end
        if (hit) begin
            status = mshr_pkg::MISS_PENDING;
        end else if (!found) begin
            status = mshr_pkg::MISS_FULL;
        end else begin
            status = mshr_pkg::MISS_ALLOC;
        end
    endtask

    task automatic check_flags(input int r);
        int n_valid;
        n_valid = 0;
        for (int s = 0; s < `MSHR_SETS; s++) begin
            for (int w = 0; w < `MSHR_WAYS; w++) begin
                n_valid += int'(ref_valid[s][w]);
            end
        end
        if (empty !== (n_valid == 0) || full !== (n_valid == `MSHR_SETS * `MSHR_WAYS)) begin
            $display("Error at %0t: row %0d empty/full %b/%b with %0d slots in use",
                     $time, r, empty, full, n_valid);
            row_errors++;
        end
    endtask

    task automatic apply_request(input int r);
        mshr_pkg::miss_status_e      exp_status;
        logic [`MSHR_WAY_WIDTH-1:0]  exp_way;
        int                          set;
        set = int'(row_nline[r][`MSHR_SET_WIDTH-1:0]);
        predict_request(row_nline[r], exp_status, exp_way);
        if (exp_status != row_status[r]) begin
            $display("Row %0d: table expects %s but the reference model gives %s",
                     r, row_status[r].name(), exp_status.name());
            row_errors++;
        end
        miss_req      = 1'b1;
        miss_nline    = row_nline[r];
        miss_req_id   = row_req_id[r];
        miss_word     = row_word[r];
        miss_need_rsp = row_need_rsp[r];
        @(posedge clk_i);
        #2;
        miss_req = 1'b0;
        @(negedge clk_i);
        if (dec_valid !== 1'b1) begin
            $display("Row %0d: no decode strobe one cycle after the request", r);
            row_errors++;
        end else if (dec_status !== exp_status) begin
            $display("Error at %0t: row %0d status %s, expected %s",
                     $time, r, dec_status.name(), exp_status.name());
            row_errors++;
        end
        if (exp_status == mshr_pkg::MISS_ALLOC) begin
            if (mem_req !== 1'b1) begin
                $display("Row %0d: no memory read issued for a new line", r);
                row_errors++;
            end else if (mem_nline !== row_nline[r] || mem_set !== row_nline[r][1:0] ||
                         mem_way !== exp_way) begin
                $display("Error at %0t: row %0d memory read %h set %0d way %0d, expected way %0d",
                         $time, r, mem_nline, mem_set, mem_way, exp_way);
                row_errors++;
            end
            ref_valid[set][exp_way]    = 1'b1;
            ref_nline[set][exp_way]    = row_nline[r];
            ref_req_id[set][exp_way]   = row_req_id[r];
            ref_word[set][exp_way]     = row_word[r];
            ref_need_rsp[set][exp_way] = row_need_rsp[r];
        end else if (mem_req !== 1'b0) begin
            $display("Error at %0t: row %0d memory read on a rejected request", $time, r);
            row_errors++;
        end
        @(posedge clk_i);
        #1;
        check_flags(r);
        #1;
    endtask

    task automatic apply_refill(input int r);
        int   set;
        int   way;
        logic exp_rsp;
        set     = int'(row_set[r]);
        way     = int'(row_way[r]);
        exp_rsp = ref_valid[set][way] && ref_need_rsp[set][way];
        if (!ref_valid[set][way]) begin
            $display("Row %0d: table refills a slot that is not allocated", r);
            row_errors++;
        end else if (exp_rsp != row_rsp[r]) begin
            $display("Row %0d: table response flag disagrees with the reference model", r);
            row_errors++;
        end
        refill     = 1'b1;
        refill_set = row_set[r];
        refill_way = row_way[r];
        @(posedge clk_i);
        #2;
        refill = 1'b0;
        @(negedge clk_i);
        if (exp_rsp) begin
            if (rsp_valid !== 1'b1) begin
                $display("Row %0d: no response one cycle after the refill", r);
                row_errors++;
            end else if (rsp_req_id !== ref_req_id[set][way] ||
                         rsp_word !== ref_word[set][way] ||
                         rsp_cache_set !== ref_nline[set][way][`CACHE_SET_WIDTH-1:0] ||
                         rsp_cache_tag !== ref_nline[set][way][`NLINE_WIDTH-1:`CACHE_SET_WIDTH]) begin
                $display("Error at %0t: row %0d response id %h word %h line %h:%h, expected %h",
                         $time, r, rsp_req_id, rsp_word, rsp_cache_tag, rsp_cache_set,
                         ref_nline[set][way]);
                row_errors++;
            end
        end else if (rsp_valid !== 1'b0) begin
            $display("Error at %0t: row %0d response for a slot without need_rsp", $time, r);
            row_errors++;
        end
        if (dec_valid !== 1'b0 || mem_req !== 1'b0) begin
            $display("Error at %0t: row %0d decode active during a refill", $time, r);
            row_errors++;
        end
        ref_valid[set][way] = 1'b0;
        @(posedge clk_i);
        #1;
        check_flags(r);
        #1;
    endtask

    initial begin
        #(WATCHDOG_NS);
        $display("Watchdog expired after %0d ns before all rows were applied", WATCHDOG_NS);
        $display("Test failed");
        $finish;
    end

    initial begin
        clk_i         = 1'b0;
        rst_ni        = 1'b0;
        miss_req      = 1'b0;
        miss_nline    = '0;
        miss_req_id   = '0;
        miss_word     = '0;
        miss_need_rsp = 1'b0;
        refill        = 1'b0;
        refill_set    = '0;
        refill_way    = '0;
        seed          = 32'hfc00;
        errors        = 0;
        failed_rows   = 0;
        for (int s = 0; s < `MSHR_SETS; s++) begin
            for (int w = 0; w < `MSHR_WAYS; w++) begin
                ref_valid[s][w] = 1'b0;
            end
        end
        load_table();
        repeat (RST_CYCLES) @(posedge clk_i);
        #2;
        rst_ni = 1'b1;
        @(posedge clk_i);
        #2;
        if (empty !== 1'b1 || full !== 1'b0 || dec_valid !== 1'b0 || mem_req !== 1'b0 ||
            rsp_valid !== 1'b0) begin
            $display("Error at %0t: outputs not idle after reset", $time);
            errors++;
        end
        for (int r = 0; r < n_rows; r++) begin
            row_errors = 0;
            if (row_is_refill[r]) begin
                apply_refill(r);
            end else begin
                apply_request(r);
            end
            if (row_errors > 0) begin
                failed_rows++;
            end
            errors += row_errors;
            $display("Row %0d %s: %s", r, row_is_refill[r] ? "refill " : "request",
                     row_errors == 0 ? "ok" : "FAILED");
        end
        $display("Rows run: %0d, rows failed: %0d, errors: %0d", n_rows, failed_rows, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+.
mshr_pkg.sv
mshr_sram.sv
mshr.sv
miss_req_decode.sv
miss_refill.sv
miss_handler_top.sv
miss_handler_asserts.sv
tb_miss_handler.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_miss_handler
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Test completed successfully

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
